//--- compile.f
design/spi_master_pkg.sv
design/wb_decoder.sv
design/spi_ctrl_regs.sv
design/wb_stream_bridge.sv
design/rx_fifo.sv
design/spi_shifter.sv
design/wb_to_spi_master.sv
tests/wb_to_spi_master_assertions.sv
tests/tb_wb_to_spi_master.sv

//--- design/rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_fifo
#(
	parameter int FIFO_DEPTH = 16
) (
	input  logic clk,
	input  logic sresetn,

	input  logic                  push,
	input  spi_master_pkg::byte_t push_data,
	input  logic                  pop,
	output spi_master_pkg::byte_t pop_data,
	output logic                  empty,
	output logic                  full
);

localparam int AW = $clog2(FIFO_DEPTH);

spi_master_pkg::byte_t mem [FIFO_DEPTH];

// Extra top bit tells a full buffer from an empty one
logic [AW:0] wr_ptr;
logic [AW:0] rd_ptr;
logic        do_push;
logic        do_pop;

assign empty = (wr_ptr == rd_ptr);
assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

assign do_push = push && !full;
assign do_pop  = pop && !empty;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
	end
	else
	begin
		if (do_push)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (do_push)
		mem[wr_ptr[AW-1:0]] <= push_data;
end

// Oldest entry is always visible at the output
assign pop_data = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

//--- design/spi_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_regs
(
	input  logic clk,
	input  logic sresetn,

	input  logic                  we,
	input  spi_master_pkg::byte_t dat_w,
	input  logic                  cfg_stb,
	input  logic                  inject_stb,

	output logic                  cfg_ack,
	output logic                  inject_ack,
	output spi_master_pkg::byte_t cfg_dat,
	output spi_master_pkg::byte_t inject_dat,

	output logic ss,
	output logic discard,
	output logic inject_valid,
	input  logic inject_take
);

spi_master_pkg::byte_t config_reg;
spi_master_pkg::byte_t inject_cnt;
logic cfg_wr;
logic inject_wr;

// One access per bus cycle, the ack blocks a repeat
assign cfg_wr    = cfg_stb && we && !cfg_ack;
assign inject_wr = inject_stb && we && !inject_ack;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		config_reg <= spi_master_pkg::CONFIG_RESET;
		inject_cnt <= '0;
		cfg_ack    <= 1'b0;
		inject_ack <= 1'b0;
	end
	else
	begin
		cfg_ack    <= cfg_stb && !cfg_ack;
		inject_ack <= inject_stb && !inject_ack;

		if (cfg_wr)
			config_reg <= dat_w;

		// A new write restarts the count even with bytes still pending
		if (inject_wr)
			inject_cnt <= dat_w;
		else if (inject_take && inject_valid)
			inject_cnt <= inject_cnt - 8'd1;
	end
end

assign cfg_dat    = config_reg;
assign inject_dat = inject_cnt;

assign ss           = config_reg[spi_master_pkg::CFG_SS_BIT];
assign discard      = config_reg[spi_master_pkg::CFG_DISCARD_BIT];
assign inject_valid = (inject_cnt != '0);

endmodule

`default_nettype wire

//--- design/spi_master_pkg.sv
`default_nettype none

package spi_master_pkg;

	// Wishbone address width
	localparam int ADDR_BITS = 8;

	typedef logic [7:0] byte_t;

	// Register map, anything else is unmapped
	typedef enum logic [ADDR_BITS-1:0] {
		REG_CONFIG = 8'd1,
		REG_DATA   = 8'd2,
		REG_INJECT = 8'd3
	} reg_addr_e;

	// Config register fields
	localparam int CFG_SS_BIT      = 0;
	localparam int CFG_DISCARD_BIT = 1;

	// Chip select deasserted, received bytes kept
	localparam byte_t CONFIG_RESET = 8'h01;

	// Sent for every injected transfer
	localparam byte_t DUMMY_BYTE = 8'hff;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_LOW,
		SPI_HIGH
	} spi_state_e;

endpackage

`default_nettype wire

//--- design/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter
#(
	parameter int CLK_DIV = 2
) (
	input  logic clk,
	input  logic sresetn,

	input  logic                  tx_valid,
	input  spi_master_pkg::byte_t tx_data,
	input  logic                  inject_valid,
	output logic                  tx_ready,
	output logic                  inject_take,

	output logic                  rx_valid,
	output spi_master_pkg::byte_t rx_data,

	output logic sck,
	output logic mosi,
	input  logic miso
);

localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

spi_master_pkg::spi_state_e state;
logic [DIV_W-1:0]      div_cnt;
logic [2:0]            bit_cnt;
spi_master_pkg::byte_t tx_shift;
spi_master_pkg::byte_t rx_shift;
logic                  div_last;
logic                  accept;

assign div_last = (div_cnt == DIV_W'(CLK_DIV - 1));

// Bus byte has priority over injected dummies
assign tx_ready    = (state == spi_master_pkg::SPI_IDLE);
assign accept      = tx_ready && (tx_valid || inject_valid);
assign inject_take = tx_ready && !tx_valid && inject_valid;

// Mode 0, sck low at rest and MSB out first
assign sck     = (state == spi_master_pkg::SPI_HIGH);
assign mosi    = (state != spi_master_pkg::SPI_IDLE) && tx_shift[7];
assign rx_data = rx_shift;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		state    <= spi_master_pkg::SPI_IDLE;
		div_cnt  <= '0;
		bit_cnt  <= '0;
		rx_valid <= 1'b0;
	end
	else
	begin
		rx_valid <= 1'b0;
		case (state)
			spi_master_pkg::SPI_IDLE:
			begin
				div_cnt <= '0;
				bit_cnt <= '0;
				if (accept)
					state <= spi_master_pkg::SPI_LOW;
			end
			spi_master_pkg::SPI_LOW:
			begin
				if (div_last)
				begin
					div_cnt <= '0;
					state   <= spi_master_pkg::SPI_HIGH;
				end
				else
					div_cnt <= div_cnt + 1'b1;
			end
			spi_master_pkg::SPI_HIGH:
			begin
				if (div_last)
				begin
					div_cnt <= '0;
					if (bit_cnt == 3'd7)
					begin
						// Eighth bit done, byte complete
						state    <= spi_master_pkg::SPI_IDLE;
						rx_valid <= 1'b1;
					end
					else
					begin
						state   <= spi_master_pkg::SPI_LOW;
						bit_cnt <= bit_cnt + 3'd1;
					end
				end
				else
					div_cnt <= div_cnt + 1'b1;
			end
			default: state <= spi_master_pkg::SPI_IDLE;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (accept)
		tx_shift <= tx_valid ? tx_data : spi_master_pkg::DUMMY_BYTE;
	else if ((state == spi_master_pkg::SPI_HIGH) && div_last)
		tx_shift <= {tx_shift[6:0], 1'b0};

	// miso taken on the rising sck edge
	if ((state == spi_master_pkg::SPI_LOW) && div_last)
		rx_shift <= {rx_shift[6:0], miso};
end

endmodule

`default_nettype wire

//--- design/wb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decoder
(
	input  logic clk,
	input  logic sresetn,

	input  logic [spi_master_pkg::ADDR_BITS-1:0] adr,
	input  spi_master_pkg::byte_t                dat_w,
	input  logic                                 we,
	input  logic                                 stb,
	input  logic                                 cyc,
	output spi_master_pkg::byte_t                dat_r,
	output logic                                 ack,

	output logic cfg_stb,
	output logic data_stb,
	output logic inject_stb,

	input  logic                  cfg_ack,
	input  logic                  data_ack,
	input  logic                  inject_ack,
	input  spi_master_pkg::byte_t cfg_dat,
	input  spi_master_pkg::byte_t data_dat,
	input  spi_master_pkg::byte_t inject_dat
);

logic active;
logic cfg_hit;
logic data_hit;
logic inject_hit;
logic unmapped_hit;
logic unmapped_ack;

assign active = stb && cyc;

always_comb
begin
	cfg_hit    = 1'b0;
	data_hit   = 1'b0;
	inject_hit = 1'b0;
	case (adr)
		spi_master_pkg::REG_CONFIG: cfg_hit    = 1'b1;
		spi_master_pkg::REG_DATA:   data_hit   = 1'b1;
		spi_master_pkg::REG_INJECT: inject_hit = 1'b1;
		default: ;
	endcase
end

assign unmapped_hit = !(cfg_hit || data_hit || inject_hit);

assign cfg_stb    = active && cfg_hit;
assign data_stb   = active && data_hit;
assign inject_stb = active && inject_hit;

// Unmapped cycles complete here with zero data and their write data is dropped
always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		unmapped_ack <= 1'b0;
	end
	else
	begin
		unmapped_ack <= active && unmapped_hit && !unmapped_ack;
	end
end

// Only the acking target contributes to the read data
assign dat_r = ({8{cfg_ack}} & cfg_dat)
	| ({8{data_ack}} & data_dat)
	| ({8{inject_ack}} & inject_dat);

assign ack = cfg_ack || data_ack || inject_ack || unmapped_ack;

endmodule

`default_nettype wire

//--- design/wb_stream_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stream_bridge
(
	input  logic clk,
	input  logic sresetn,

	input  logic                  we,
	input  spi_master_pkg::byte_t dat_w,
	input  logic                  data_stb,
	output logic                  data_ack,
	output spi_master_pkg::byte_t data_dat,

	// Towards the shifter
	output logic                  tx_valid,
	output spi_master_pkg::byte_t tx_data,
	input  logic                  tx_ready,

	// From the receive FIFO
	output logic                  pop,
	input  logic                  empty,
	input  spi_master_pkg::byte_t fifo_data
);

logic wr_req;
logic rd_req;
logic wr_done;

// The ack cycle closes the request so each bus cycle moves one byte
assign wr_req = data_stb && we && !data_ack;
assign rd_req = data_stb && !we && !data_ack;

// Byte stays offered until the shifter goes idle and takes it
assign tx_valid = wr_req;
assign tx_data  = dat_w;
assign wr_done  = wr_req && tx_ready;

// Read waits here while the FIFO is empty
assign pop = rd_req && !empty;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		data_ack <= 1'b0;
	end
	else
	begin
		data_ack <= wr_done || pop;
	end
end

// Head of the FIFO captured as it is popped
always_ff @(posedge clk)
begin
	if (pop)
		data_dat <= fifo_data;
end

endmodule

`default_nettype wire

//--- design/wb_to_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_to_spi_master
#(
	parameter int CLK_DIV    = 2,
	parameter int FIFO_DEPTH = 16
) (
	input  logic clk,
	input  logic sresetn,

	input  logic [spi_master_pkg::ADDR_BITS-1:0] wb_adr,
	input  spi_master_pkg::byte_t                wb_dat_w,
	input  logic                                 wb_we,
	input  logic                                 wb_stb,
	input  logic                                 wb_cyc,
	output spi_master_pkg::byte_t                wb_dat_r,
	output logic                                 wb_ack,

	output logic sck,
	output logic ss,
	output logic mosi,
	input  logic miso
);

logic                  cfg_stb, data_stb, inject_stb;
logic                  cfg_ack, data_ack, inject_ack;
spi_master_pkg::byte_t cfg_dat, data_dat, inject_dat;

logic                  discard;
logic                  inject_valid;
logic                  inject_take;

logic                  tx_valid;
logic                  tx_ready;
spi_master_pkg::byte_t tx_data;

logic                  rx_valid;
spi_master_pkg::byte_t rx_data;

logic                  fifo_push;
logic                  fifo_pop;
logic                  fifo_empty;
logic                  fifo_full;
spi_master_pkg::byte_t fifo_data;

wb_decoder u_decoder (
	.clk        (clk),
	.sresetn    (sresetn),
	.adr        (wb_adr),
	.dat_w      (wb_dat_w),
	.we         (wb_we),
	.stb        (wb_stb),
	.cyc        (wb_cyc),
	.dat_r      (wb_dat_r),
	.ack        (wb_ack),
	.cfg_stb    (cfg_stb),
	.data_stb   (data_stb),
	.inject_stb (inject_stb),
	.cfg_ack    (cfg_ack),
	.data_ack   (data_ack),
	.inject_ack (inject_ack),
	.cfg_dat    (cfg_dat),
	.data_dat   (data_dat),
	.inject_dat (inject_dat)
);

spi_ctrl_regs u_regs (
	.clk          (clk),
	.sresetn      (sresetn),
	.we           (wb_we),
	.dat_w        (wb_dat_w),
	.cfg_stb      (cfg_stb),
	.inject_stb   (inject_stb),
	.cfg_ack      (cfg_ack),
	.inject_ack   (inject_ack),
	.cfg_dat      (cfg_dat),
	.inject_dat   (inject_dat),
	.ss           (ss),
	.discard      (discard),
	.inject_valid (inject_valid),
	.inject_take  (inject_take)
);

wb_stream_bridge u_bridge (
	.clk       (clk),
	.sresetn   (sresetn),
	.we        (wb_we),
	.dat_w     (wb_dat_w),
	.data_stb  (data_stb),
	.data_ack  (data_ack),
	.data_dat  (data_dat),
	.tx_valid  (tx_valid),
	.tx_data   (tx_data),
	.tx_ready  (tx_ready),
	.pop       (fifo_pop),
	.empty     (fifo_empty),
	.fifo_data (fifo_data)
);

// Received byte is dropped when discarding or when there is no room
assign fifo_push = rx_valid && !discard && !fifo_full;

rx_fifo #(
	.FIFO_DEPTH (FIFO_DEPTH)
) u_fifo (
	.clk       (clk),
	.sresetn   (sresetn),
	.push      (fifo_push),
	.push_data (rx_data),
	.pop       (fifo_pop),
	.pop_data  (fifo_data),
	.empty     (fifo_empty),
	.full      (fifo_full)
);

spi_shifter #(
	.CLK_DIV (CLK_DIV)
) u_shifter (
	.clk          (clk),
	.sresetn      (sresetn),
	.tx_valid     (tx_valid),
	.tx_data      (tx_data),
	.inject_valid (inject_valid),
	.tx_ready     (tx_ready),
	.inject_take  (inject_take),
	.rx_valid     (rx_valid),
	.rx_data      (rx_data),
	.sck          (sck),
	.mosi         (mosi),
	.miso         (miso)
);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Wishbone SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_wb_to_spi_master -Mdir obj_dir -f compile.f

# A fatal check ends the simulator with an error, the log decides the result
./obj_dir/Vtb_wb_to_spi_master > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	echo "run_sim: pass"
	exit 0
fi
echo "run_sim: fail"
exit 1

//--- tests/spi_cases.txt
# op adr byte expected, all hex; write ignores expected, read checks expected
# spi queues a transfer: byte goes out on miso, expected must appear on mosi
read  01 00 01
read  03 00 00
write 01 00 00
read  01 00 00
read  7f 00 00
spi   00 3c a5
write 02 a5 00
read  02 00 3c
spi   00 11 01
spi   00 22 80
spi   00 33 7e
write 02 01 00
write 02 80 00
write 02 7e 00
read  02 00 11
read  02 00 22
read  02 00 33
spi   00 c1 ff
spi   00 c2 ff
spi   00 c3 ff
write 03 03 00
read  02 00 c1
read  02 00 c2
read  02 00 c3
read  03 00 00
# discard on, first byte is dropped, second finishes after discard is cleared
write 01 02 00
spi   00 5a 96
write 02 96 00
spi   00 e7 18
write 02 18 00
write 01 00 00
read  02 00 e7

//--- tests/tb_wb_to_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_to_spi_master;

localparam int CLK_DIV     = 2;
localparam int FIFO_DEPTH  = 16;
// A data access may sit behind a whole transfer
localparam int ACK_LIMIT   = 1000;
localparam int DRAIN_LIMIT = 4000;

logic                                 clk = 1'b0;
logic                                 sresetn;
logic [spi_master_pkg::ADDR_BITS-1:0] wb_adr;
spi_master_pkg::byte_t                wb_dat_w;
logic                                 wb_we;
logic                                 wb_stb;
logic                                 wb_cyc;
spi_master_pkg::byte_t                wb_dat_r;
logic                                 wb_ack;
logic                                 sck;
logic                                 ss;
logic                                 mosi;
logic                                 miso = 1'b0;

// SPI slave model state, one queue entry per expected transfer
spi_master_pkg::byte_t miso_q[$];
spi_master_pkg::byte_t mosi_exp_q[$];
logic                  sck_q = 1'b0;
logic [2:0]            bit_idx = 3'd0;
spi_master_pkg::byte_t slave_rx = 8'h00;

always #10 clk = ~clk;

wb_to_spi_master #(
	.CLK_DIV    (CLK_DIV),
	.FIFO_DEPTH (FIFO_DEPTH)
) u_dut (
	.clk      (clk),
	.sresetn  (sresetn),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_we    (wb_we),
	.wb_stb   (wb_stb),
	.wb_cyc   (wb_cyc),
	.wb_dat_r (wb_dat_r),
	.wb_ack   (wb_ack),
	.sck      (sck),
	.ss       (ss),
	.mosi     (mosi),
	.miso     (miso)
);

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("Simulation FAILED");
	$fatal(1, "run stopped at %0t", $time);
endtask

task automatic check_reg_read(
	input spi_master_pkg::byte_t                got,
	input spi_master_pkg::byte_t                exp,
	input logic [spi_master_pkg::ADDR_BITS-1:0] adr
);
	if (got !== exp)
		abort_run($sformatf("error at %0t: read of address %02h returned %02h, expected %02h",
			$time, adr, got, exp));
endtask

task automatic check_mosi_byte(input spi_master_pkg::byte_t got, input spi_master_pkg::byte_t exp);
	if (got !== exp)
		abort_run($sformatf("error at %0t: mosi carried %02h, expected %02h", $time, got, exp));
endtask

task automatic check_count(input spi_master_pkg::byte_t got, input spi_master_pkg::byte_t exp);
	if (got !== exp)
		abort_run($sformatf("error at %0t: inject count is %0d, expected %0d", $time, got, exp));
endtask

task automatic check_pin(input logic got, input logic exp, input string name);
	if (got !== exp)
		abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
endtask

// One classic Wishbone cycle after a random idle gap
task automatic wb_access(
	input  logic                                 write,
	input  logic [spi_master_pkg::ADDR_BITS-1:0] adr,
	input  spi_master_pkg::byte_t                wdata,
	output spi_master_pkg::byte_t                rdata
);
	int unsigned gap;
	int          waited;
	gap = $urandom % 4;
	repeat (gap) @(posedge clk);
	@(posedge clk);
	wb_adr   <= adr;
	wb_dat_w <= wdata;
	wb_we    <= write;
	wb_stb   <= 1'b1;
	wb_cyc   <= 1'b1;
	waited = 0;
	@(posedge clk);
	while (!wb_ack && waited < ACK_LIMIT)
	begin
		waited++;
		@(posedge clk);
	end
	if (!wb_ack)
		abort_run($sformatf("Timeout waiting for the Wishbone ack at address %02h", adr));
	rdata = wb_dat_r;
	wb_stb <= 1'b0;
	wb_cyc <= 1'b0;
	wb_we  <= 1'b0;
endtask

task automatic run_case(
	input string                                op,
	input logic [spi_master_pkg::ADDR_BITS-1:0] adr,
	input spi_master_pkg::byte_t                dat,
	input spi_master_pkg::byte_t                exp
);
	spi_master_pkg::byte_t rdata;
	if (op == "write")
		wb_access(1'b1, adr, dat, rdata);
	else if (op == "read")
	begin
		wb_access(1'b0, adr, 8'h00, rdata);
		if (adr == spi_master_pkg::REG_INJECT)
			check_count(rdata, exp);
		else
			check_reg_read(rdata, exp, adr);
	end
	else if (op == "spi")
	begin
		miso_q.push_back(dat);
		mosi_exp_q.push_back(exp);
	end
	else
		abort_run($sformatf("Unknown operation %s in the cases file", op));
endtask

// SPI slave, sck edges seen through the clock
always @(posedge clk)
begin
	if (sck && !sck_q && !ss)
	begin
		slave_rx = {slave_rx[6:0], mosi};
		if (bit_idx == 3'd7)
		begin
			bit_idx = 3'd0;
			if (mosi_exp_q.size() == 0)
				abort_run("An SPI transfer happened with no expected byte queued");
			else
			begin
				check_mosi_byte(slave_rx, mosi_exp_q.pop_front());
				void'(miso_q.pop_front());
			end
		end
		else
			bit_idx = bit_idx + 3'd1;
	end
	// Next bit is presented while sck is low
	if (!sck)
		miso <= (miso_q.size() > 0) ? miso_q[0][3'd7 - bit_idx] : 1'b0;
	sck_q <= sck;
end

initial
begin
	int                                 fd;
	int                                 n;
	int                                 waited;
	string                              line;
	string                              op;
	logic [spi_master_pkg::ADDR_BITS-1:0] adr;
	spi_master_pkg::byte_t              dat;
	spi_master_pkg::byte_t              exp;

	void'($urandom(32'h6298_af32));
	sresetn  = 1'b0;
	wb_adr   = '0;
	wb_dat_w = '0;
	wb_we    = 1'b0;
	wb_stb   = 1'b0;
	wb_cyc   = 1'b0;
	repeat (16) @(posedge clk);
	sresetn <= 1'b1;
	@(posedge clk);
	check_pin(ss, 1'b1, "ss");
	check_pin(sck, 1'b0, "sck");
	check_pin(mosi, 1'b0, "mosi");

	fd = $fopen("tests/spi_cases.txt", "r");
	if (fd == 0)
		abort_run("Could not open tests/spi_cases.txt");
	while (!$feof(fd))
	begin
		line = "";
		n = $fgets(line, fd);
		if (n > 1 && line.getc(0) != "#")
		begin
			n = $sscanf(line, "%s %h %h %h", op, adr, dat, exp);
			if (n != 4)
				abort_run($sformatf("Malformed line in the cases file: %s", line));
			run_case(op, adr, dat, exp);
		end
	end
	$fclose(fd);

	// Every queued transfer must have been seen on the wire
	waited = 0;
	while (mosi_exp_q.size() != 0 && waited < DRAIN_LIMIT)
	begin
		waited++;
		@(posedge clk);
	end
	if (mosi_exp_q.size() == 0)
	begin
		$display("Simulation PASSED");
		$finish;
	end
	else
		abort_run("Timeout waiting for the queued SPI transfers to finish");
end

endmodule

`default_nettype wire

//--- tests/wb_to_spi_master_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module wb_to_spi_master_assertions
(
	input  logic                       clk,
	input  logic                       sresetn,
	input  logic                       wb_stb,
	input  logic                       wb_cyc,
	input  logic                       wb_ack,
	input  logic                       sck,
	input  logic                       ss,
	input  spi_master_pkg::spi_state_e shifter_state
);

// One ack per bus cycle
ack_single_cycle: assert property (@(posedge clk) disable iff (!sresetn) wb_ack |=> !wb_ack)
	else $error("ack stayed high for two cycles");

ack_needs_request: assert property (@(posedge clk) disable iff (!sresetn)
	wb_ack |-> (wb_stb && wb_cyc))
	else $error("ack without an active stb and cyc");

// Mode 0 clock rests low and stays low for the first cycle out of idle
sck_low_when_idle: assert property (@(posedge clk) disable iff (!sresetn)
	(shifter_state == spi_master_pkg::SPI_IDLE) |-> !sck ##1 !sck)
	else $error("sck high while idle or right after leaving idle");

ss_high_after_reset: assert property (@(posedge clk) $rose(sresetn) |-> ss)
	else $error("ss low when reset is released");

endmodule

bind wb_to_spi_master wb_to_spi_master_assertions u_assertions (
	.clk           (clk),
	.sresetn       (sresetn),
	.wb_stb        (wb_stb),
	.wb_cyc        (wb_cyc),
	.wb_ack        (wb_ack),
	.sck           (sck),
	.ss            (ss),
	.shifter_state (u_shifter.state)
);

`default_nettype wire
